//--- hdl/xbar_settings.svh
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// Number of requester ports on the crossbar.
`define XBAR_NUM_REQ 2
// Number of memory targets behind the crossbar.
`define XBAR_NUM_TGT 2
// Address width in bits. The top bit picks the target.
`define XBAR_ADDR_W 8
// Data width in bits for both read and write data.
`define XBAR_DATA_W 16
// Outstanding transactions allowed per requester before it is stalled.
`define XBAR_MAX_PEND 4

`endif

//--- hdl/xbar_pkg.sv
`include "xbar_settings.svh"

package xbar_pkg;

  // Index of a requester port.
  // It is carried with every request and echoed back by the target,
  // so the crossbar can route the response home without any tracking state.
  typedef logic [((`XBAR_NUM_REQ > 1) ? $clog2(`XBAR_NUM_REQ) : 1)-1:0] src_t;

  // Request payload.
  // The top address bit is the target select, the remaining bits are the
  // word address inside the target.
  typedef struct packed {
    logic [`XBAR_ADDR_W-1:0] addr;
    logic [`XBAR_DATA_W-1:0] wdata;
    // High for a write, low for a read.
    logic                    we;
    src_t                    src;
  } xbar_req_t;

  // Response payload.
  // The target always returns the word that was stored before the access,
  // for a write as well as for a read.
  typedef struct packed {
    logic [`XBAR_DATA_W-1:0] rdata;
    // Copy of the src field of the request this response belongs to.
    src_t                    src;
  } xbar_rsp_t;

endpackage

//--- hdl/port_isolate.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module port_isolate (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                isolate_i,
  output logic                isolated_o,
  // Upstream side, facing the requester.
  input  logic                slv_req_valid_i,
  input  xbar_pkg::xbar_req_t slv_req_i,
  output logic                slv_req_ready_o,
  output logic                slv_rsp_valid_o,
  output xbar_pkg::xbar_rsp_t slv_rsp_o,
  input  logic                slv_rsp_ready_i,
  // Downstream side, facing the crossbar core.
  output logic                mst_req_valid_o,
  output xbar_pkg::xbar_req_t mst_req_o,
  input  logic                mst_req_ready_i,
  input  logic                mst_rsp_valid_i,
  input  xbar_pkg::xbar_rsp_t mst_rsp_i,
  output logic                mst_rsp_ready_o
);

  // The counter has to hold every value from zero up to the pending limit.
  localparam int unsigned CntW = $clog2(`XBAR_MAX_PEND + 1);

  logic [CntW-1:0] pend_q;
  logic            pend_full;
  logic            block;
  logic            req_fire;
  logic            rsp_fire;

  // New requests are held off while isolating or when the port has too many in flight.
  // Both valid and ready are cut, so neither side can see a handshake.
  assign pend_full = (pend_q == CntW'(`XBAR_MAX_PEND));
  assign block     = isolate_i | pend_full;

  assign mst_req_valid_o = slv_req_valid_i & ~block;
  assign slv_req_ready_o = mst_req_ready_i & ~block;
  assign mst_req_o       = slv_req_i;

  // Responses are never blocked. Outstanding work must drain for the clear to finish.
  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign slv_rsp_o       = mst_rsp_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;

  assign req_fire = mst_req_valid_o & mst_req_ready_i;
  assign rsp_fire = mst_rsp_valid_i & slv_rsp_ready_i;

  // The port counts as isolated once nothing it issued is still in flight.
  assign isolated_o = isolate_i & (pend_q == '0);

  // Requests accepted minus responses delivered.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= '0;
    end else if (req_fire && !rsp_fire) begin
      pend_q <= pend_q + 1'b1;
    end else if (!req_fire && rsp_fire) begin
      pend_q <= pend_q - 1'b1;
    end
  end

  // A response can only come back for a request that was accepted earlier.
  a_no_underflow : assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_fire |-> (pend_q != '0));

  // The full stall must keep the count within the limit at all times.
  a_no_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
    pend_q <= CntW'(`XBAR_MAX_PEND));

endmodule

//--- hdl/rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter #(
  parameter type         payload_t = logic,
  parameter int unsigned NumIn     = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic     [NumIn-1:0] valid_i,
  input  payload_t [NumIn-1:0] data_i,
  output logic     [NumIn-1:0] ready_o,
  output logic                 valid_o,
  output payload_t             data_o,
  input  logic                 ready_i
);

  localparam int unsigned IdxW = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxW-1:0] ptr_q;
  logic [IdxW-1:0] free_idx;
  logic [IdxW-1:0] sel;
  logic [IdxW-1:0] sel_next;
  logic [IdxW-1:0] lock_idx_q;
  logic            lock_q;

  // Search for the first valid input at or after the pointer.
  // The loop walks from the far end back, so the nearest hit is written last.
  always_comb begin
    free_idx = ptr_q;
    for (int k = NumIn - 1; k >= 0; k--) begin
      if (valid_i[(int'(ptr_q) + k) % NumIn]) begin
        free_idx = IdxW'((int'(ptr_q) + k) % NumIn);
      end
    end
  end

  // A stalled grant stays put.
  // If the locked input withdraws its request the search result takes over again.
  assign sel     = (lock_q && valid_i[lock_idx_q]) ? lock_idx_q : free_idx;
  assign valid_o = valid_i[sel];
  assign data_o  = data_i[sel];

  always_comb begin
    ready_o      = '0;
    ready_o[sel] = ready_i & valid_o;
  end

  // Priority moves to the input just after the winner.
  assign sel_next = (sel == IdxW'(NumIn - 1)) ? '0 : sel + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= valid_o & ~ready_i;
      lock_idx_q <= sel;
      if (valid_o && ready_i) begin
        ptr_q <= sel_next;
      end
    end
  end

  a_ready_onehot : assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(ready_o));

  // A stalled output keeps its payload until the transfer, unless it is withdrawn.
  a_stall_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i) |=> (!valid_o || $stable(data_o)));

endmodule

//--- hdl/xbar_core.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_core (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // Requester side.
  input  logic                [`XBAR_NUM_REQ-1:0] req_valid_i,
  input  xbar_pkg::xbar_req_t [`XBAR_NUM_REQ-1:0] req_i,
  output logic                [`XBAR_NUM_REQ-1:0] req_ready_o,
  output logic                [`XBAR_NUM_REQ-1:0] rsp_valid_o,
  output xbar_pkg::xbar_rsp_t [`XBAR_NUM_REQ-1:0] rsp_o,
  input  logic                [`XBAR_NUM_REQ-1:0] rsp_ready_i,
  // Target side.
  output logic                [`XBAR_NUM_TGT-1:0] tgt_req_valid_o,
  output xbar_pkg::xbar_req_t [`XBAR_NUM_TGT-1:0] tgt_req_o,
  input  logic                [`XBAR_NUM_TGT-1:0] tgt_req_ready_i,
  input  logic                [`XBAR_NUM_TGT-1:0] tgt_rsp_valid_i,
  input  xbar_pkg::xbar_rsp_t [`XBAR_NUM_TGT-1:0] tgt_rsp_i,
  output logic                [`XBAR_NUM_TGT-1:0] tgt_rsp_ready_o
);

  import xbar_pkg::*;

  // Target picked by each requester, taken from the top address bit.
  logic [`XBAR_NUM_REQ-1:0] req_tgt;

  // Request arbiters, indexed by target first and requester second.
  logic [`XBAR_NUM_TGT-1:0][`XBAR_NUM_REQ-1:0] req_arb_valid;
  logic [`XBAR_NUM_TGT-1:0][`XBAR_NUM_REQ-1:0] req_arb_ready;

  // Response arbiters, indexed by requester first and target second.
  logic [`XBAR_NUM_REQ-1:0][`XBAR_NUM_TGT-1:0] rsp_arb_valid;
  logic [`XBAR_NUM_REQ-1:0][`XBAR_NUM_TGT-1:0] rsp_arb_ready;

  // Request decode.
  // Each requester raises valid only at the arbiter of its chosen target.
  // Its ready comes back from that same arbiter.
  always_comb begin
    for (int r = 0; r < `XBAR_NUM_REQ; r++) begin
      req_tgt[r] = req_i[r].addr[`XBAR_ADDR_W-1];
    end
    for (int t = 0; t < `XBAR_NUM_TGT; t++) begin
      for (int r = 0; r < `XBAR_NUM_REQ; r++) begin
        req_arb_valid[t][r] = req_valid_i[r] && (req_tgt[r] == 1'(t));
      end
    end
    for (int r = 0; r < `XBAR_NUM_REQ; r++) begin
      req_ready_o[r] = req_arb_ready[req_tgt[r]][r];
    end
  end

  // Response steering.
  // The echoed src field names the requester whose arbiter sees the response.
  always_comb begin
    for (int r = 0; r < `XBAR_NUM_REQ; r++) begin
      for (int t = 0; t < `XBAR_NUM_TGT; t++) begin
        rsp_arb_valid[r][t] = tgt_rsp_valid_i[t] && (tgt_rsp_i[t].src == src_t'(r));
      end
    end
    for (int t = 0; t < `XBAR_NUM_TGT; t++) begin
      tgt_rsp_ready_o[t] = rsp_arb_ready[tgt_rsp_i[t].src][t];
    end
  end

  // All request arbiters see every payload; the gated valids decide who competes.
  for (genvar t = 0; t < `XBAR_NUM_TGT; t++) begin : gen_req_arb
    rr_arbiter #(
      .payload_t (xbar_req_t),
      .NumIn     (`XBAR_NUM_REQ)
    ) i_req_arb (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (req_arb_valid[t]),
      .data_i  (req_i),
      .ready_o (req_arb_ready[t]),
      .valid_o (tgt_req_valid_o[t]),
      .data_o  (tgt_req_o[t]),
      .ready_i (tgt_req_ready_i[t])
    );

    // Every response must belong to a requester that exists.
    a_src_range : assert property (@(posedge clk_i) disable iff (rst_i)
      tgt_rsp_valid_i[t] |-> (int'(tgt_rsp_i[t].src) < `XBAR_NUM_REQ));
  end

  // Two targets can answer the same requester at once, so responses are arbitrated too.
  for (genvar r = 0; r < `XBAR_NUM_REQ; r++) begin : gen_rsp_arb
    rr_arbiter #(
      .payload_t (xbar_rsp_t),
      .NumIn     (`XBAR_NUM_TGT)
    ) i_rsp_arb (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (rsp_arb_valid[r]),
      .data_i  (tgt_rsp_i),
      .ready_o (rsp_arb_ready[r]),
      .valid_o (rsp_valid_o[r]),
      .data_o  (rsp_o[r]),
      .ready_i (rsp_ready_i[r])
    );
  end

endmodule

//--- hdl/xbar_clearable.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_clearable (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    clr_i,
  output logic                                    clr_ack_o,
  input  logic                [`XBAR_NUM_REQ-1:0] req_valid_i,
  input  xbar_pkg::xbar_req_t [`XBAR_NUM_REQ-1:0] req_i,
  output logic                [`XBAR_NUM_REQ-1:0] req_ready_o,
  output logic                [`XBAR_NUM_REQ-1:0] rsp_valid_o,
  output xbar_pkg::xbar_rsp_t [`XBAR_NUM_REQ-1:0] rsp_o,
  input  logic                [`XBAR_NUM_REQ-1:0] rsp_ready_i,
  output logic                [`XBAR_NUM_TGT-1:0] tgt_req_valid_o,
  output xbar_pkg::xbar_req_t [`XBAR_NUM_TGT-1:0] tgt_req_o,
  input  logic                [`XBAR_NUM_TGT-1:0] tgt_req_ready_i,
  input  logic                [`XBAR_NUM_TGT-1:0] tgt_rsp_valid_i,
  input  xbar_pkg::xbar_rsp_t [`XBAR_NUM_TGT-1:0] tgt_rsp_i,
  output logic                [`XBAR_NUM_TGT-1:0] tgt_rsp_ready_o
);

  import xbar_pkg::*;

  logic                     isolate;
  logic [`XBAR_NUM_REQ-1:0] isolated;
  logic                     isolating_d;
  logic                     isolating_q;
  logic                     core_rst;

  // Requester channels between the isolate gates and the core.
  logic      [`XBAR_NUM_REQ-1:0] iso_req_valid;
  xbar_req_t [`XBAR_NUM_REQ-1:0] iso_req;
  logic      [`XBAR_NUM_REQ-1:0] iso_req_ready;
  logic      [`XBAR_NUM_REQ-1:0] iso_rsp_valid;
  xbar_rsp_t [`XBAR_NUM_REQ-1:0] iso_rsp;
  logic      [`XBAR_NUM_REQ-1:0] iso_rsp_ready;

  // Isolation starts with clr_i and is held by the flag until every port has drained.
  // A short clear pulse is therefore enough to finish the whole sequence.
  assign isolate     = clr_i | isolating_q;
  assign clr_ack_o   = &isolated;
  assign isolating_d = isolate & ~clr_ack_o;

  // The core is idle once acknowledged, so resetting it only restores arbiter priority.
  assign core_rst = rst_i | clr_ack_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      isolating_q <= 1'b0;
    end else begin
      isolating_q <= isolating_d;
    end
  end

  for (genvar r = 0; r < `XBAR_NUM_REQ; r++) begin : gen_isolate
    port_isolate i_port_isolate (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .isolate_i       (isolate),
      .isolated_o      (isolated[r]),
      .slv_req_valid_i (req_valid_i[r]),
      .slv_req_i       (req_i[r]),
      .slv_req_ready_o (req_ready_o[r]),
      .slv_rsp_valid_o (rsp_valid_o[r]),
      .slv_rsp_o       (rsp_o[r]),
      .slv_rsp_ready_i (rsp_ready_i[r]),
      .mst_req_valid_o (iso_req_valid[r]),
      .mst_req_o       (iso_req[r]),
      .mst_req_ready_i (iso_req_ready[r]),
      .mst_rsp_valid_i (iso_rsp_valid[r]),
      .mst_rsp_i       (iso_rsp[r]),
      .mst_rsp_ready_o (iso_rsp_ready[r])
    );
  end

  xbar_core i_xbar_core (
    .clk_i           (clk_i),
    .rst_i           (core_rst),
    .req_valid_i     (iso_req_valid),
    .req_i           (iso_req),
    .req_ready_o     (iso_req_ready),
    .rsp_valid_o     (iso_rsp_valid),
    .rsp_o           (iso_rsp),
    .rsp_ready_i     (iso_rsp_ready),
    .tgt_req_valid_o (tgt_req_valid_o),
    .tgt_req_o       (tgt_req_o),
    .tgt_req_ready_i (tgt_req_ready_i),
    .tgt_rsp_valid_i (tgt_rsp_valid_i),
    .tgt_rsp_i       (tgt_rsp_i),
    .tgt_rsp_ready_o (tgt_rsp_ready_o)
  );

endmodule

//--- dv/tb_mem_target.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module tb_mem_target #(
  parameter int unsigned TgtIdx = 0
) (
  input  logic                clk_i,
  input  logic                rst_i,
  // High for random ready and random latency, low for an always ready target.
  input  logic                rand_i,
  input  logic                req_valid_i,
  input  xbar_pkg::xbar_req_t req_i,
  output logic                req_ready_o,
  output logic                rsp_valid_o,
  output xbar_pkg::xbar_rsp_t rsp_o,
  input  logic                rsp_ready_i
);

  import xbar_pkg::*;

  logic [`XBAR_DATA_W-1:0] mem [128];
  xbar_rsp_t               rsp_q [$];
  int unsigned             due_q [$];
  int unsigned             cyc;
  xbar_rsp_t               rsp;

  // Every word starts with a value built from its full address and the target index.
  initial begin
    for (int a = 0; a < 128; a++) begin
      mem[a] = (16'(a) * 16'h0101) ^ (16'(TgtIdx) * 16'h5A5A);
    end
  end

  // Responses leave in request order.
  // Each one becomes visible between 1 and 4 cycles after its request.
  always @(posedge clk_i) begin
    if (rst_i) begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
      cyc = 0;
    end else begin
      cyc++;
      if (req_valid_i && req_ready_o) begin
        rsp.rdata = mem[req_i.addr[6:0]];
        rsp.src   = req_i.src;
        if (req_i.we) begin
          mem[req_i.addr[6:0]] = req_i.wdata;
        end
        rsp_q.push_back(rsp);
        due_q.push_back(cyc + (rand_i ? $urandom_range(3, 0) : 0));
      end
      if (rsp_valid_o && rsp_ready_i) begin
        void'(rsp_q.pop_front());
        void'(due_q.pop_front());
      end
      req_ready_o <= rand_i ? ($urandom_range(3, 0) != 0) : 1'b1;
      // The head only changes on a transfer, so a pending response stays stable.
      if (rsp_q.size() > 0 && due_q[0] <= cyc) begin
        rsp_valid_o <= 1'b1;
        rsp_o       <= rsp_q[0];
      end else begin
        rsp_valid_o <= 1'b0;
      end
    end
  end

endmodule

//--- dv/tb_xbar_clearable.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module tb_xbar_clearable;

  import xbar_pkg::*;

  // Transactions over all tests; the run limit follows from it.
  localparam int unsigned NumTxn    = 121;
  localparam int unsigned MaxCycles = NumTxn * 16 + 200;

  logic                     clk;
  logic                     rst;
  logic                     clr;
  logic                     clr_ack;
  logic [`XBAR_NUM_REQ-1:0] req_valid;
  xbar_req_t [`XBAR_NUM_REQ-1:0] req;
  logic [`XBAR_NUM_REQ-1:0] req_ready;
  logic [`XBAR_NUM_REQ-1:0] rsp_valid;
  xbar_rsp_t [`XBAR_NUM_REQ-1:0] rsp;
  logic [`XBAR_NUM_REQ-1:0] rsp_ready = '1;
  logic [`XBAR_NUM_TGT-1:0] tgt_req_valid;
  xbar_req_t [`XBAR_NUM_TGT-1:0] tgt_req;
  logic [`XBAR_NUM_TGT-1:0] tgt_req_ready;
  logic [`XBAR_NUM_TGT-1:0] tgt_rsp_valid;
  xbar_rsp_t [`XBAR_NUM_TGT-1:0] tgt_rsp;
  logic [`XBAR_NUM_TGT-1:0] tgt_rsp_ready;

  logic              rand_tgt;
  logic              rand_rsp;
  logic              fair_on;
  logic              fair_next;
  logic              first_pending;
  logic [15:0]       shadow [2][128];
  logic [15:0]       exp_q [2][2][$];
  int                outstanding [2];
  int                errors;
  int                err_mark;
  int                checks;
  int unsigned       cyc = 0;

  xbar_clearable u_xbar_clearable (
    .clk_i (clk), .rst_i (rst), .clr_i (clr), .clr_ack_o (clr_ack),
    .req_valid_i (req_valid), .req_i (req), .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid), .rsp_o (rsp), .rsp_ready_i (rsp_ready),
    .tgt_req_valid_o (tgt_req_valid), .tgt_req_o (tgt_req), .tgt_req_ready_i (tgt_req_ready),
    .tgt_rsp_valid_i (tgt_rsp_valid), .tgt_rsp_i (tgt_rsp), .tgt_rsp_ready_o (tgt_rsp_ready)
  );

  for (genvar t = 0; t < `XBAR_NUM_TGT; t++) begin : gen_mem
    tb_mem_target #(.TgtIdx (t)) u_mem (
      .clk_i (clk), .rst_i (rst), .rand_i (rand_tgt),
      .req_valid_i (tgt_req_valid[t]), .req_i (tgt_req[t]), .req_ready_o (tgt_req_ready[t]),
      .rsp_valid_o (tgt_rsp_valid[t]), .rsp_o (tgt_rsp[t]), .rsp_ready_i (tgt_rsp_ready[t])
    );
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Old word comes back, then a write updates the shadow copy.
  function automatic logic [15:0] expected_rsp(input xbar_req_t q);
    logic [15:0] old;
    old = shadow[q.addr[7]][q.addr[6:0]];
    if (q.we) begin
      shadow[q.addr[7]][q.addr[6:0]] = q.wdata;
    end
    return old;
  endfunction

  // Returns once ready is seen, so the handshake lands on the next rising edge.
  task automatic issue(input int r, input logic [7:0] addr, input logic we,
                       input logic [15:0] wdata);
    @(posedge clk);
    req_valid[r] <= 1'b1;
    req[r]       <= '{addr: addr, wdata: wdata, we: we, src: src_t'(r)};
    do @(negedge clk); while (!req_ready[r]);
  endtask

  task automatic idle(input int r);
    @(posedge clk);
    req_valid[r] <= 1'b0;
  endtask

  task automatic rand_traffic(input int r, input int n);
    for (int i = 0; i < n; i++) begin
      issue(r, 8'($urandom) & 8'h87, 1'($urandom), 16'($urandom));
    end
    idle(r);
  endtask

  task automatic drain();
    do @(negedge clk); while (outstanding[0] != 0 || outstanding[1] != 0);
  endtask

  task automatic clear_pulse();
    @(posedge clk);
    clr <= 1'b1;
    do @(negedge clk); while (!clr_ack);
    @(posedge clk);
    clr <= 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // All checks sample at the falling edge, where every signal has settled.
  always @(negedge clk) begin : monitor
    int        t;
    logic [15:0] exp;
    if (!rst) begin
      assert (!(clr_ack && (outstanding[0] != 0 || outstanding[1] != 0))) else begin
        $display("Clear acknowledged while responses are still outstanding");
        errors++;
      end
      for (int r = 0; r < 2; r++) begin
        if (req_valid[r] && req_ready[r]) begin
          assert (!clr) else begin
            $display("Requester %0d accepted a request while clear is active", r);
            errors++;
          end
          outstanding[r]++;
        end
      end
      for (int k = 0; k < 2; k++) begin
        if (tgt_req_valid[k] && tgt_req_ready[k]) begin
          exp_q[tgt_req[k].src][k].push_back(expected_rsp(tgt_req[k]));
          if (k == 0 && fair_on) begin
            assert (tgt_req[k].src == fair_next) else begin
              $display("Mismatch tgt_req_o.src: expected %h got %h", fair_next, tgt_req[k].src);
              errors++;
            end
            fair_next = ~fair_next;
          end
          if (k == 1 && first_pending) begin
            assert (tgt_req[k].src == 1'b0) else begin
              $display("Mismatch tgt_req_o.src: expected %h got %h", 1'b0, tgt_req[k].src);
              errors++;
            end
            first_pending = 1'b0;
          end
        end
      end
      for (int r = 0; r < 2; r++) begin
        if (rsp_valid[r] && rsp_ready[r]) begin
          t = -1;
          // The target side handshake tells which target this response came from.
          for (int k = 0; k < 2; k++) begin
            if (tgt_rsp_valid[k] && tgt_rsp_ready[k] && tgt_rsp[k].src == src_t'(r)) begin
              t = k;
            end
          end
          assert (t >= 0 && exp_q[r][t].size() > 0) else begin
            $display("Requester %0d got a response with no request waiting for it", r);
            errors++;
          end
          if (t >= 0 && exp_q[r][t].size() > 0) begin
            exp = exp_q[r][t].pop_front();
            checks++;
            assert (rsp[r].rdata == exp) else begin
              $display("Mismatch rsp_o.rdata req %0d: expected %h got %h", r, exp, rsp[r].rdata);
              errors++;
            end
            assert (rsp[r].src == src_t'(r)) else begin
              $display("Mismatch rsp_o.src: expected %h got %h", r[0], rsp[r].src);
              errors++;
            end
          end
          outstanding[r]--;
        end
      end
    end
  end

  always @(posedge clk) begin
    rsp_ready <= rand_rsp ? 2'($urandom) : 2'b11;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MaxCycles) begin
      $display("Timeout after %0d cycles", cyc);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(29));
    rst = 1'b1;
    clr = 1'b0;
    req_valid = '0;
    req = '0;
    rand_tgt = 1'b0;
    rand_rsp = 1'b0;
    fair_on = 1'b0;
    fair_next = 1'b0;
    first_pending = 1'b0;
    outstanding = '{0, 0};
    errors = 0;
    err_mark = 0;
    checks = 0;
    for (int t = 0; t < 2; t++) begin
      for (int a = 0; a < 128; a++) begin
        shadow[t][a] = (16'(a) * 16'h0101) ^ (16'(t) * 16'h5A5A);
      end
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Write then read back one word per requester and target.
    for (int r = 0; r < 2; r++) begin
      for (int t = 0; t < 2; t++) begin
        issue(r, {t[0], 7'(r * 8 + 1)}, 1'b1, 16'hA000 + 16'(r * 16 + t));
        issue(r, {t[0], 7'(r * 8 + 1)}, 1'b0, 16'h0);
      end
      idle(r);
    end
    drain();
    end_test("directed accesses");

    // A clear with nothing in flight resets arbiter priority before the fairness run.
    clear_pulse();
    fair_on = 1'b1;
    fork
      begin
        for (int i = 0; i < 8; i++) issue(0, 8'(i), 1'b0, 16'h0);
        idle(0);
      end
      begin
        for (int i = 0; i < 8; i++) issue(1, 8'(16 + i), 1'b0, 16'h0);
        idle(1);
      end
    join
    drain();
    fair_on = 1'b0;
    end_test("fair arbitration");

    rand_tgt = 1'b1;
    rand_rsp = 1'b1;
    fork
      rand_traffic(0, 40);
      rand_traffic(1, 40);
    join
    drain();
    rand_rsp = 1'b0;
    end_test("random traffic");

    // Requester 0 is the last to win target 1, so only the clear can hand priority back to it.
    // Requester 0 then keeps a request pending through the clear.
    rand_traffic(1, 3);
    for (int i = 0; i < 3; i++) issue(0, 8'h82 + 8'(i), 1'b1, 16'($urandom));
    @(posedge clk);
    assert (outstanding[0] + outstanding[1] > 0) else begin
      $display("Clear raised with no requests outstanding");
      errors++;
    end
    clr <= 1'b1;
    req[0] <= '{addr: 8'h05, wdata: 16'h0, we: 1'b0, src: src_t'(0)};
    do @(negedge clk); while (!clr_ack);
    @(posedge clk);
    clr <= 1'b0;
    do @(negedge clk); while (!req_ready[0]);
    idle(0);
    drain();
    end_test("clear during traffic");

    first_pending = 1'b1;
    fork
      begin
        issue(0, 8'h83, 1'b1, 16'h1234);
        idle(0);
      end
      begin
        issue(1, 8'h84, 1'b1, 16'h5678);
        idle(1);
      end
    join
    fork
      rand_traffic(0, 4);
      rand_traffic(1, 4);
    join
    drain();
    assert (!first_pending) else begin
      $display("No request reached target 1 after the clear");
      errors++;
    end
    end_test("priority after clear");

    $display("Checked %0d responses, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+hdl
hdl/xbar_pkg.sv
hdl/port_isolate.sv
hdl/rr_arbiter.sv
hdl/xbar_core.sv
hdl/xbar_clearable.sv
dv/tb_mem_target.sv
dv/tb_xbar_clearable.sv

//--- run_sim.sh
#!/bin/sh
# Compile the crossbar testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_xbar_clearable -o sim_xbar
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_xbar > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
